//--- src/vic_timing_pkg.sv
package vic_timing_pkg;

    // chip selection, encoded as on the config pins
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6569     = 2'd1,
        CHIP_6567R56A = 2'd2,
        // treated as a 6569
        CHIP_UNUSED   = 2'd3
    } chip_e;

    // horizontal pixel position within a line
    typedef logic [9:0] raster_x_t;
    // line number within a frame
    typedef logic [8:0] raster_line_t;
    // 8-pixel cycle index within a line
    typedef logic [6:0] cycle_num_t;
    // tick index inside one phi half
    typedef logic [3:0] half_phase_t;

    // last pixel and last line of each chip type
    typedef struct packed {
        raster_x_t    raster_x_max;
        raster_line_t raster_y_max;
    } chip_limits_t;

    // current beam position, cycle_num is raster_x / 8
    typedef struct packed {
        raster_x_t    raster_x;
        raster_line_t raster_line;
        cycle_num_t   cycle_num;
    } raster_pos_t;

    // phi level, tick within the half, and the end-of-pixel strobe
    typedef struct packed {
        logic        phi;
        half_phase_t half_phase;
        logic        dot_tick;
    } phase_t;

    // display window in which bad lines may occur
    localparam raster_line_t BADLINE_FIRST_LINE = 9'd48;
    localparam raster_line_t BADLINE_END_LINE   = 9'd248;

    function automatic chip_limits_t chip_limits_of(input chip_e chip);
        chip_limits_t lim;
        case (chip)
            CHIP_6567R56A: begin
                // 512 pixels, 262 lines
                lim.raster_x_max = 10'd511;
                lim.raster_y_max = 9'd261;
            end
            CHIP_6567R8: begin
                // 520 pixels, 263 lines
                lim.raster_x_max = 10'd519;
                lim.raster_y_max = 9'd262;
            end
            default: begin
                // 6569 PAL, 504 pixels and 312 lines
                lim.raster_x_max = 10'd503;
                lim.raster_y_max = 9'd311;
            end
        endcase
        return lim;
    endfunction

endpackage

//--- src/vic_bus_pkg.sv
package vic_bus_pkg;

    // frame control bits as seen in reg $d011
    typedef struct packed {
        // display enable, only sampled on line 48
        logic       den;
        // fine vertical scroll, selects the bad line row
        logic [2:0] yscroll;
    } frame_ctrl_t;

    // raster interrupt control
    typedef struct packed {
        // line on which the interrupt fires
        logic [8:0] raster_irq_compare;
        // gates the latch onto irq
        logic       irq_enable;
        // one-clock acknowledge pulse
        logic       irq_clr;
    } irq_ctrl_t;

    // DRAM refresh row address
    typedef logic [7:0] refc_t;

endpackage

//--- src/phase_gen.sv
`timescale 1ns/1ps

module phase_gen (
    input  logic                   clk_dot4x,
    input  logic                   rst,
    output vic_timing_pkg::phase_t phase_o
);

    import vic_timing_pkg::*;

    // tick within the current phi half, 0..15
    half_phase_t half_phase;
    // phi level, low half first
    logic        phi;
    // high on tick 3 of each 4-tick pixel
    logic        dot_tick;

    // --------------------
    // tick counter and phi
    // --------------------

    // 16 ticks per half, so 32 ticks per phi cycle
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            half_phase <= '0;
            phi        <= 1'b0;
        end else begin
            // rolls over from 15 to 0 on its own
            half_phase <= half_phase + 4'd1;
            // phi flips together with the half_phase wrap
            if (half_phase == 4'd15) begin
                phi <= ~phi;
            end
        end
    end

    // pixel strobe, the next edge moves to the next pixel
    assign dot_tick = (half_phase[1:0] == 2'd3);

    assign phase_o.phi        = phi;
    assign phase_o.half_phase = half_phase;
    assign phase_o.dot_tick   = dot_tick;

endmodule

//--- src/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_timing_pkg::chip_e       chip_i,
    input  vic_timing_pkg::phase_t      phase_i,
    output vic_timing_pkg::raster_pos_t pos_o
);

    import vic_timing_pkg::*;

    // limits follow the chip input without latching
    chip_limits_t limits;
    raster_x_t    raster_x;
    raster_line_t raster_line;
    // last pixel of the line reached
    logic         end_of_line;
    // last line of the frame reached
    logic         end_of_frame;

    assign limits = chip_limits_of(chip_i);

    // >= so that a live switch to a shorter chip still wraps
    assign end_of_line  = (raster_x >= limits.raster_x_max);
    assign end_of_frame = (raster_line >= limits.raster_y_max);

    // --------------------
    // pixel and line count
    // --------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            raster_x    <= '0;
            raster_line <= '0;
        end else if (phase_i.dot_tick) begin
            if (end_of_line) begin
                raster_x <= '0;
                // line steps only at the horizontal wrap
                if (end_of_frame) begin
                    raster_line <= '0;
                end else begin
                    raster_line <= raster_line + 9'd1;
                end
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end
    end

    assign pos_o.raster_x    = raster_x;
    assign pos_o.raster_line = raster_line;
    // 8 pixels per phi cycle
    assign pos_o.cycle_num   = raster_x[9:3];

endmodule

//--- src/badline_detect.sv
`timescale 1ns/1ps

module badline_detect (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_timing_pkg::phase_t      phase_i,
    input  vic_timing_pkg::raster_pos_t pos_i,
    input  vic_bus_pkg::frame_ctrl_t    frame_ctrl_i,
    output logic                        badline_o
);

    import vic_timing_pkg::*;

    // once per cycle, second tick of the low half
    logic eval;
    // bad lines allowed in this frame
    logic allow;
    // allow flag as updated by this evaluation
    logic allow_next;
    logic in_window;
    logic yscroll_match;

    assign eval = ~phase_i.phi && (phase_i.half_phase == 4'd1);

    // den only counts on line 48, window closes on line 248
    always_comb begin
        allow_next = allow;
        if (frame_ctrl_i.den && (pos_i.raster_line == BADLINE_FIRST_LINE)) begin
            allow_next = 1'b1;
        end
        if (pos_i.raster_line == BADLINE_END_LINE) begin
            allow_next = 1'b0;
        end
    end

    assign in_window = (pos_i.raster_line >= BADLINE_FIRST_LINE) &&
                       (pos_i.raster_line < BADLINE_END_LINE);

    // row selected by the fine scroll
    assign yscroll_match = (pos_i.raster_line[2:0] == frame_ctrl_i.yscroll);

    // result holds until the next cycle's evaluation
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            allow     <= 1'b0;
            badline_o <= 1'b0;
        end else if (eval) begin
            allow     <= allow_next;
            badline_o <= yscroll_match && allow_next && in_window;
        end
    end

endmodule

//--- src/raster_irq.sv
`timescale 1ns/1ps

module raster_irq (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_timing_pkg::phase_t      phase_i,
    input  vic_timing_pkg::raster_pos_t pos_i,
    input  vic_bus_pkg::irq_ctrl_t      irq_ctrl_i,
    output logic                        irq_o
);

    // compare point, tick 8 of the low half
    logic eval;
    logic line_match;
    // interrupt latch, held until acknowledged
    logic irq_latch;
    // set while the current line already fired
    logic triggered;

    assign eval       = ~phase_i.phi && (phase_i.half_phase == 4'd8);
    assign line_match = (pos_i.raster_line == irq_ctrl_i.raster_irq_compare);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            irq_latch <= 1'b0;
            triggered <= 1'b0;
        end else begin
            if (eval) begin
                if (line_match) begin
                    triggered <= 1'b1;
                    // fire only on the first match of the line
                    if (!triggered) begin
                        irq_latch <= 1'b1;
                    end
                end else begin
                    // rearm once the line moves off the compare value
                    triggered <= 1'b0;
                end
            end
            // acknowledge wins over a set in the same tick
            if (irq_ctrl_i.irq_clr) begin
                irq_latch <= 1'b0;
            end
        end
    end

    // latch runs even when disabled, enabling shows a pending one
    assign irq_o = irq_latch & irq_ctrl_i.irq_enable;

endmodule

//--- src/dram_refresh.sv
`timescale 1ns/1ps

module dram_refresh #(
    parameter int REFRESH_FIRST_CYCLE = 11,
    parameter int REFRESH_CYCLES      = 5
) (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_timing_pkg::phase_t      phase_i,
    input  vic_timing_pkg::raster_pos_t pos_i,
    output vic_bus_pkg::refc_t          refc_o
);

    import vic_timing_pkg::*;

    // cycle that just ended, wraps to 127 in cycle 0
    cycle_num_t prev_cycle;
    // the cycle that just ended did a refresh access
    logic       prev_was_refresh;
    logic       step;

    assign prev_cycle       = pos_i.cycle_num - 7'd1;
    assign prev_was_refresh = (prev_cycle >= 7'(REFRESH_FIRST_CYCLE)) &&
                              (prev_cycle < 7'(REFRESH_FIRST_CYCLE + REFRESH_CYCLES));
    assign step             = ~phase_i.phi && (phase_i.half_phase == 4'd1);

    // counts down once after each refresh access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            refc_o <= 8'hff;
        end else if (step) begin
            // restart at the top of every frame
            if ((pos_i.cycle_num == 7'd1) && (pos_i.raster_line == 9'd0)) begin
                refc_o <= 8'hff;
            end else if (prev_was_refresh) begin
                refc_o <= refc_o - 8'd1;
            end
        end
    end

endmodule

//--- src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int CHARS_BA_FIRST_CYCLE = 12,
    parameter int CHARS_BA_LAST_CYCLE  = 54,
    parameter int BA_LEAD_CYCLES       = 3
) (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  vic_timing_pkg::phase_t      phase_i,
    input  vic_timing_pkg::raster_pos_t pos_i,
    input  logic                        badline_i,
    output logic                        ba_o,
    output logic                        aec_o
);

    localparam int CNT_W = $clog2(BA_LEAD_CYCLES + 1);

    // phi-high halves seen with BA low, saturating
    logic [CNT_W-1:0] lead_cnt;
    // character fetch slots of the line
    logic             ba_window;
    // CPU has had its lead time, VIC takes the high halves
    logic             lead_done;
    logic             high_end;

    assign ba_window = (pos_i.cycle_num >= 7'(CHARS_BA_FIRST_CYCLE)) &&
                       (pos_i.cycle_num <= 7'(CHARS_BA_LAST_CYCLE));
    assign lead_done = (lead_cnt == CNT_W'(BA_LEAD_CYCLES));
    assign high_end  = phase_i.phi && (phase_i.half_phase == 4'd15);

    // --------------------
    // BA
    // --------------------
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            ba_o <= 1'b1;
        end else begin
            ba_o <= ~(badline_i && ba_window);
        end
    end

    // --------------------
    // AEC cascade
    // --------------------

    // a raised BA hands the next high half straight back to the CPU
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            lead_cnt <= '0;
        end else if (ba_o) begin
            lead_cnt <= '0;
        end else if (high_end && !lead_done) begin
            lead_cnt <= lead_cnt + 1'b1;
        end
    end

    // AEC follows phi one tick late, low half always belongs to the VIC
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            aec_o <= 1'b0;
        end else begin
            aec_o <= phase_i.phi & ~lead_done;
        end
    end

endmodule

//--- src/vic_top.sv
`timescale 1ns/1ps

module vic_top #(
    parameter int REFRESH_FIRST_CYCLE  = 11,
    parameter int REFRESH_CYCLES       = 5,
    parameter int CHARS_BA_FIRST_CYCLE = 12,
    parameter int CHARS_BA_LAST_CYCLE  = 54,
    parameter int BA_LEAD_CYCLES       = 3
) (
    input  logic                         clk_dot4x,
    input  logic                         rst,
    input  vic_timing_pkg::chip_e        chip_i,
    input  vic_bus_pkg::frame_ctrl_t     frame_ctrl_i,
    input  vic_bus_pkg::irq_ctrl_t       irq_ctrl_i,
    output logic                         clk_phi_o,
    output vic_timing_pkg::raster_x_t    raster_x_o,
    output vic_timing_pkg::raster_line_t raster_line_o,
    output logic                         badline_o,
    output logic                         irq_o,
    output vic_bus_pkg::refc_t           refc_o,
    output logic                         ba_o,
    output logic                         aec_o
);

    import vic_timing_pkg::*;

    phase_t      phase;
    raster_pos_t pos;

    // --------------------
    // clocking and position
    // --------------------
    phase_gen u_phase_gen (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_o   (phase)
    );

    raster_counter u_raster_counter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .chip_i    (chip_i),
        .phase_i   (phase),
        .pos_o     (pos)
    );

    // --------------------
    // line events and bus
    // --------------------
    badline_detect u_badline_detect (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .phase_i      (phase),
        .pos_i        (pos),
        .frame_ctrl_i (frame_ctrl_i),
        .badline_o    (badline_o)
    );

    raster_irq u_raster_irq (
        .clk_dot4x  (clk_dot4x),
        .rst        (rst),
        .phase_i    (phase),
        .pos_i      (pos),
        .irq_ctrl_i (irq_ctrl_i),
        .irq_o      (irq_o)
    );

    dram_refresh #(
        .REFRESH_FIRST_CYCLE (REFRESH_FIRST_CYCLE),
        .REFRESH_CYCLES      (REFRESH_CYCLES)
    ) u_dram_refresh (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .pos_i     (pos),
        .refc_o    (refc_o)
    );

    // badline feeds the arbiter as well as the output pin
    bus_arbiter #(
        .CHARS_BA_FIRST_CYCLE (CHARS_BA_FIRST_CYCLE),
        .CHARS_BA_LAST_CYCLE  (CHARS_BA_LAST_CYCLE),
        .BA_LEAD_CYCLES       (BA_LEAD_CYCLES)
    ) u_bus_arbiter (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .phase_i   (phase),
        .pos_i     (pos),
        .badline_i (badline_o),
        .ba_o      (ba_o),
        .aec_o     (aec_o)
    );

    assign clk_phi_o     = phase.phi;
    assign raster_x_o    = pos.raster_x;
    assign raster_line_o = pos.raster_line;

endmodule

//--- testbench/vic_model.svh
`ifndef VIC_MODEL_SVH
`define VIC_MODEL_SVH

// --------------------
// reference state
// --------------------

// state the DUT should hold after the latest clock edge
logic [4:0]   exp_tick;
raster_x_t    exp_x;
raster_line_t exp_line;
logic         exp_allow;
logic         exp_badline;
logic         exp_latch;
logic         exp_triggered;
refc_t        exp_refc;
logic         exp_ba;
int unsigned  exp_lead;
logic         exp_aec;
// completed lines since time 0
int unsigned  lines_seen = 0;

// line length in pixels per chip
function automatic int unsigned pixels_per_line(input chip_e c);
    case (c)
        CHIP_6567R56A: return 512;
        CHIP_6567R8:   return 520;
        default:       return 504;
    endcase
endfunction

// frame height in lines per chip
function automatic int unsigned lines_per_frame(input chip_e c);
    case (c)
        CHIP_6567R56A: return 262;
        CHIP_6567R8:   return 263;
        default:       return 312;
    endcase
endfunction

// one clock edge, inputs as they stood before the edge
task automatic advance_model(input logic rst_v, input chip_e chip_v,
                             input frame_ctrl_t fc, input irq_ctrl_t ic);
    int unsigned cyc;
    int          prev_cyc;
    logic        allow_now;
    if (rst_v) begin
        exp_tick      = '0;
        exp_x         = '0;
        exp_line      = '0;
        exp_allow     = 1'b0;
        exp_badline   = 1'b0;
        exp_latch     = 1'b0;
        exp_triggered = 1'b0;
        exp_refc      = 8'hff;
        exp_ba        = 1'b1;
        exp_lead      = 0;
        exp_aec       = 1'b0;
    end else begin
        cyc      = exp_x / 8;
        prev_cyc = int'(cyc) - 1;
        // aec trails phi by a tick, high halves go to the VIC once the lead is used up
        exp_aec = exp_tick[4] && (exp_lead != BA_LEAD_CYCLES);
        // count phi-high halves that end with BA low
        if (exp_ba) begin
            exp_lead = 0;
        end else if ((exp_tick == 31) && (exp_lead < BA_LEAD_CYCLES)) begin
            exp_lead = exp_lead + 1;
        end
        exp_ba = !(exp_badline && (cyc >= CHARS_BA_FIRST_CYCLE) &&
                   (cyc <= CHARS_BA_LAST_CYCLE));
        // bad line and refresh step at tick 1 of the low half
        if (exp_tick == 1) begin
            allow_now = exp_allow;
            if (fc.den && (exp_line == BADLINE_FIRST_LINE)) allow_now = 1'b1;
            if (exp_line == BADLINE_END_LINE) allow_now = 1'b0;
            exp_allow   = allow_now;
            exp_badline = allow_now && ((exp_line % 8) == fc.yscroll) &&
                          (exp_line >= BADLINE_FIRST_LINE) && (exp_line < BADLINE_END_LINE);
            if ((cyc == 1) && (exp_line == 0)) begin
                exp_refc = 8'hff;
            end else if ((prev_cyc >= REFRESH_FIRST_CYCLE) &&
                         (prev_cyc < REFRESH_FIRST_CYCLE + REFRESH_CYCLES)) begin
                exp_refc = exp_refc - 8'd1;
            end
        end
        // raster compare at tick 8, one shot per line
        if (exp_tick == 8) begin
            if (exp_line == ic.raster_irq_compare) begin
                if (!exp_triggered) exp_latch = 1'b1;
                exp_triggered = 1'b1;
            end else begin
                exp_triggered = 1'b0;
            end
        end
        if (ic.irq_clr) exp_latch = 1'b0;
        // pixel ends on every fourth tick
        if ((exp_tick % 4) == 3) begin
            if (exp_x + 1 >= pixels_per_line(chip_v)) begin
                exp_x      = '0;
                lines_seen = lines_seen + 1;
                if (exp_line + 1 >= lines_per_frame(chip_v)) exp_line = '0;
                else exp_line = exp_line + 9'd1;
            end else begin
                exp_x = exp_x + 10'd1;
            end
        end
        exp_tick = exp_tick + 5'd1;
    end
endtask

`endif

//--- testbench/tb_vic_top.sv
`timescale 1ns/1ps

module tb_vic_top;

    import vic_timing_pkg::*;
    import vic_bus_pkg::*;

    localparam int REFRESH_FIRST_CYCLE  = 11;
    localparam int REFRESH_CYCLES       = 5;
    localparam int CHARS_BA_FIRST_CYCLE = 12;
    localparam int CHARS_BA_LAST_CYCLE  = 54;
    localparam int BA_LEAD_CYCLES       = 3;
    localparam logic [31:0] SEED        = 32'h5a0b9f91;
    // 4 clocks per pixel over the three runs, margin covers the resets
    localparam int TIMEOUT_CYCLES = 4 * (512 * 272 + 504 * 60 + 520 * 60) + 1000;

    logic         clk_dot4x;
    logic         rst;
    chip_e        chip;
    frame_ctrl_t  frame_ctrl;
    irq_ctrl_t    irq_ctrl;
    logic         clk_phi;
    raster_x_t    raster_x;
    raster_line_t raster_line;
    logic         badline;
    logic         irq;
    refc_t        refc;
    logic         ba;
    logic         aec;

    // inputs as the DUT saw them at the last edge
    logic         rst_prev;
    chip_e        chip_prev;
    frame_ctrl_t  frame_prev;
    irq_ctrl_t    irq_prev;
    logic         checking = 1'b0;
    string        run_name = "none";
    int           run_idx = 0;
    int unsigned  check_count = 0;
    int unsigned  error_count = 0;
    int unsigned  cycle_count = 0;

    `include "vic_model.svh"

    vic_top #(
        .REFRESH_FIRST_CYCLE  (REFRESH_FIRST_CYCLE),
        .REFRESH_CYCLES       (REFRESH_CYCLES),
        .CHARS_BA_FIRST_CYCLE (CHARS_BA_FIRST_CYCLE),
        .CHARS_BA_LAST_CYCLE  (CHARS_BA_LAST_CYCLE),
        .BA_LEAD_CYCLES       (BA_LEAD_CYCLES)
    ) dut0 (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .chip_i        (chip),
        .frame_ctrl_i  (frame_ctrl),
        .irq_ctrl_i    (irq_ctrl),
        .clk_phi_o     (clk_phi),
        .raster_x_o    (raster_x),
        .raster_line_o (raster_line),
        .badline_o     (badline),
        .irq_o         (irq),
        .refc_o        (refc),
        .ba_o          (ba),
        .aec_o         (aec)
    );

    // 8 ns dot4x clock
    initial begin
        clk_dot4x = 1'b0;
        forever begin
            #4 clk_dot4x = ~clk_dot4x;
        end
    end

    // --------------------
    // stimulus
    // --------------------

    // new line settings at cycle 0, tick 4; model state equals the DUT state here
    // second run keeps den low from line 47 on, so all of line 48 sees it low
    always @(posedge clk_dot4x) begin
        if ((exp_tick == 4) && (exp_x < 8)) begin
            frame_ctrl.den <= ((run_idx == 1) &&
                               ((exp_line == BADLINE_FIRST_LINE - 1) ||
                                (exp_line == BADLINE_FIRST_LINE))) ?
                              1'b0 : (($urandom % 4) != 0);
            frame_ctrl.yscroll <= 3'($urandom);
            irq_ctrl.raster_irq_compare <= 9'(exp_line + ($urandom % 3));
            irq_ctrl.irq_enable <= (($urandom % 4) != 0);
        end
        // occasional acknowledge pulse at tick 12
        if (exp_tick == 12) irq_ctrl.irq_clr <= (($urandom % 8) == 0);
        else irq_ctrl.irq_clr <= 1'b0;
    end

    // --------------------
    // model and sampling
    // --------------------
    always @(negedge clk_dot4x) begin
        advance_model(rst_prev, chip_prev, frame_prev, irq_prev);
        rst_prev   = rst;
        chip_prev  = chip;
        frame_prev = frame_ctrl;
        irq_prev   = irq_ctrl;
        if (checking && ((exp_tick == 4) || (exp_tick == 20))) compare_outputs();
    end

    always @(posedge clk_dot4x) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: runs did not complete within %0d clocks", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s %s: expected %0h, actual %0h (line %0d, x %0d)",
                 run_name, what, expected, actual, exp_line, exp_x);
        error_count = error_count + 1;
    endtask

    task automatic compare_outputs();
        check_count = check_count + 8;
        if (raster_x !== exp_x) report_mismatch("position x", exp_x, raster_x);
        if (raster_line !== exp_line) report_mismatch("position line", exp_line, raster_line);
        if (clk_phi !== exp_tick[4]) report_mismatch("position phi", exp_tick[4], clk_phi);
        if (badline !== exp_badline) report_mismatch("badline", exp_badline, badline);
        if (irq !== (exp_latch & irq_ctrl.irq_enable)) begin
            report_mismatch("raster_irq", exp_latch & irq_ctrl.irq_enable, irq);
        end
        if (refc !== exp_refc) report_mismatch("refresh", exp_refc, refc);
        if (ba !== exp_ba) report_mismatch("bus ba", exp_ba, ba);
        if (aec !== exp_aec) report_mismatch("bus aec", exp_aec, aec);
    endtask

    // reset, switch chip, then wait for the line count
    task automatic run_chip(input chip_e c, input string name, input int unsigned lines,
                            input int idx);
        int unsigned start_lines;
        int unsigned start_checks;
        int unsigned start_errors;
        run_name = name;
        run_idx  = idx;
        @(posedge clk_dot4x);
        rst  <= 1'b1;
        chip <= c;
        repeat (2) @(posedge clk_dot4x);
        rst <= 1'b0;
        checking     = 1'b1;
        start_lines  = lines_seen;
        start_checks = check_count;
        start_errors = error_count;
        while ((lines_seen - start_lines) < lines) @(posedge clk_dot4x);
        $display("test %s: %0d lines, %0d checks, %0d errors", name, lines,
                 check_count - start_checks, error_count - start_errors);
    endtask

    initial begin
        void'($urandom(SEED));
        rst        = 1'b1;
        chip       = CHIP_6567R56A;
        frame_ctrl = '0;
        irq_ctrl   = '0;
        rst_prev   = 1'b1;
        chip_prev  = CHIP_6567R56A;
        frame_prev = '0;
        irq_prev   = '0;
        // full frame plus 10 lines, then two shorter runs
        run_chip(CHIP_6567R56A, "6567R56A", 272, 0);
        run_chip(CHIP_6569, "6569", 60, 1);
        run_chip(CHIP_6567R8, "6567R8", 60, 2);
        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+testbench
src/vic_timing_pkg.sv
src/vic_bus_pkg.sv
src/phase_gen.sv
src/raster_counter.sv
src/badline_detect.sv
src/raster_irq.sv
src/dram_refresh.sv
src/bus_arbiter.sv
src/vic_top.sv
testbench/tb_vic_top.sv

//--- Bender.yml
package:
  name: vic_timing_core

sources:
  - files:
      - src/vic_timing_pkg.sv
      - src/vic_bus_pkg.sv
      - src/phase_gen.sv
      - src/raster_counter.sv
      - src/badline_detect.sv
      - src/raster_irq.sv
      - src/dram_refresh.sv
      - src/bus_arbiter.sv
      - src/vic_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_vic_top.sv
